// File: all.f
hdl/vga_pkg.sv
hdl/plot_pkg.sv
hdl/vga_timing.sv
hdl/adc_sampler.sv
hdl/sram_ctrl.sv
hdl/vga_pixel_out.sv
hdl/scope_top.sv
sim/sram_model.sv
sim/tb_scope_top.sv

// File: sim/tb_scope_top.sv
// testbench for the scope display: random ADC samples, shadow framebuffer and bus checks
`timescale 1ns/1ns
`default_nettype none

module tb_scope_top;

  localparam int h_vis        = 16;
  localparam int h_fp         = 2;
  localparam int h_sp         = 4;
  localparam int h_bp         = 2;
  localparam int v_vis        = 8;
  localparam int v_fp         = 1;
  localparam int v_sp         = 2;
  localparam int v_bp         = 1;
  localparam int h_tot        = h_vis + h_fp + h_sp + h_bp;
  localparam int v_tot        = v_vis + v_fp + v_sp + v_bp;
  localparam int fb_w         = h_vis / 2;
  localparam int fb_h         = v_vis;
  localparam int fb_size      = fb_w * fb_h;
  localparam int coord_span   = 12;
  localparam int clk_period   = 20;
  localparam int reset_cycles = 10;
  localparam int bursts       = 24;
  localparam int max_burst    = 4;
  localparam int max_gap      = 8;
  localparam int frame_cycles = h_tot * v_tot;
  localparam int stim_cycles  = bursts * (max_burst + max_gap);
  localparam int watchdog_ns  = (reset_cycles + stim_cycles + 3 * frame_cycles) * clk_period;

  logic        pixel_clk;
  logic        rst_n;
  logic [9:0]  adc_x;
  logic [9:0]  adc_y;
  logic        adc_red;
  logic        adc_grn;
  logic        adc_blu;
  logic        adc_valid;
  logic [17:0] sram_addr;
  wire  [15:0] sram_data;
  logic        sram_we_n;
  logic        sram_oe_n;
  logic [3:0]  vga_red;
  logic [3:0]  vga_grn;
  logic [3:0]  vga_blu;
  logic        vga_hsync;
  logic        vga_vsync;
  logic [15:0] overrun_cnt;
  logic        wr_log_valid;
  logic [17:0] wr_log_addr;
  logic [15:0] wr_log_data;
  int          wr_count;

  integer      seed;
  int          errors = 0;
  int          in_range_cnt = 0;
  int          pix_checks = 0;
  int          frames_seen = 0;

  // shadow framebuffer and what the stimulus has offered per address
  logic [2:0]  shadow [fb_size];
  logic        written [fb_size];
  logic        shown_ok [fb_size];
  logic [7:0]  sent_mask [fb_size];

  // screen position of the output, recovered from the sync edges
  int          scr_h;
  int          scr_v;
  int          cnt_h;
  int          cnt_v;
  int          pix_idx;
  logic        hs_d;
  logic        vs_d;
  logic        h_lock;
  logic        v_lock;
  logic        locked;
  logic        on_screen;
  logic        rd_slot;
  logic        pix_check;
  logic        wr_known;
  logic [11:0] pix_exp;
  logic [11:0] rgb;
  int          hs_low_len;
  int          vs_low_len;

  scope_top #(
    .adc_data_width (10),
    .sram_addr_width(18),
    .sram_data_width(16),
    .h_visible      (h_vis),
    .h_front        (h_fp),
    .h_sync         (h_sp),
    .h_back         (h_bp),
    .v_visible      (v_vis),
    .v_front        (v_fp),
    .v_sync         (v_sp),
    .v_back         (v_bp),
    .fb_width       (fb_w),
    .fb_height      (fb_h)
  ) u_dut (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .adc_x      (adc_x),
    .adc_y      (adc_y),
    .adc_red    (adc_red),
    .adc_grn    (adc_grn),
    .adc_blu    (adc_blu),
    .adc_valid  (adc_valid),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .overrun_cnt(overrun_cnt)
  );

  sram_model #(
    .addr_width(18),
    .data_width(16)
  ) u_sram (
    .log_clk     (pixel_clk),
    .addr        (sram_addr),
    .data        (sram_data),
    .we_n        (sram_we_n),
    .oe_n        (sram_oe_n),
    .wr_log_valid(wr_log_valid),
    .wr_log_addr (wr_log_addr),
    .wr_log_data (wr_log_data),
    .wr_log_count(wr_count)
  );

  // a set bit gives a full-scale channel
  function automatic logic [11:0] colour_of(input logic [2:0] pix);
    colour_of = {pix[2] ? 4'hf : 4'h0, pix[1] ? 4'hf : 4'h0, pix[0] ? 4'hf : 4'h0};
  endfunction

  task automatic drive_sample();
    int         x;
    int         y;
    logic [2:0] col;
    x = $unsigned($random(seed)) % coord_span;
    y = $unsigned($random(seed)) % coord_span;
    col = 3'($random(seed));
    adc_x = 10'(x);
    adc_y = 10'(y);
    {adc_red, adc_grn, adc_blu} = col;
    adc_valid = 1'b1;
    if (x < fb_w && y < fb_h) begin
      in_range_cnt++;
      sent_mask[y * fb_w + x][col] = 1'b1;
    end
  endtask

  initial begin
    pixel_clk = 1'b0;
    forever #(clk_period / 2) pixel_clk = ~pixel_clk;
  end

  initial begin
    for (int i = 0; i < fb_size; i++) begin
      shadow[i]    = '0;
      written[i]   = 1'b0;
      shown_ok[i]  = 1'b0;
      sent_mask[i] = '0;
    end
  end

  assign rgb    = {vga_red, vga_grn, vga_blu};
  assign locked = h_lock && v_lock;

  // sync edges snap the position, otherwise it just advances
  always @(posedge pixel_clk) begin
    int h_now;
    int v_now;
    if (!rst_n) begin
      scr_h      <= 0;
      scr_v      <= 0;
      hs_d       <= 1'b1;
      vs_d       <= 1'b1;
      h_lock     <= 1'b0;
      v_lock     <= 1'b0;
      hs_low_len <= 0;
      vs_low_len <= 0;
    end else begin
      h_now = scr_h;
      v_now = scr_v;
      hs_d <= vga_hsync;
      vs_d <= vga_vsync;
      hs_low_len <= vga_hsync ? 0 : hs_low_len + 1;
      vs_low_len <= vga_vsync ? 0 : vs_low_len + 1;
      if (hs_d && !vga_hsync) begin
        h_now = h_vis + h_fp;
        h_lock <= 1'b1;
      end
      if (vs_d && !vga_vsync) begin
        v_now = v_vis + v_fp;
        v_lock <= 1'b1;
      end
      if (h_now == h_tot - 1) begin
        scr_h <= 0;
        scr_v <= (v_now == v_tot - 1) ? 0 : v_now + 1;
      end else begin
        scr_h <= h_now + 1;
        scr_v <= v_now;
      end
      if (pix_check) begin
        pix_checks++;
      end
    end
  end

  // the timing counters run two cycles ahead of the output
  always_comb begin
    cnt_h = scr_h + 2;
    cnt_v = scr_v;
    if (cnt_h >= h_tot) begin
      cnt_h = cnt_h - h_tot;
      cnt_v = (scr_v == v_tot - 1) ? 0 : scr_v + 1;
    end
    rd_slot   = locked && cnt_h < h_vis && cnt_v < v_vis && (cnt_h % 2) == 0;
    on_screen = locked && scr_h < h_vis && scr_v < v_vis;
    pix_idx   = on_screen ? scr_v * fb_w + scr_h / 2 : 0;
    pix_check = on_screen && shown_ok[pix_idx];
    pix_exp   = colour_of(shadow[pix_idx]);
    wr_known  = (sram_addr < fb_size) && sent_mask[sram_addr[5:0]][sram_data[2:0]];
  end

  // write log first, then the frame start that covers it
  always @(negedge pixel_clk) begin
    if (rst_n && wr_log_valid && wr_log_addr < fb_size) begin
      shadow[wr_log_addr[5:0]]   = wr_log_data[2:0];
      written[wr_log_addr[5:0]]  = 1'b1;
      shown_ok[wr_log_addr[5:0]] = 1'b0;
    end
    if (locked && scr_h == h_tot - 2 && scr_v == v_tot - 1) begin
      for (int i = 0; i < fb_size; i++) begin
        if (written[i]) begin
          shown_ok[i] = 1'b1;
        end
      end
      frames_seen++;
    end
  end

  a_reset_idle : assert property (@(posedge pixel_clk) $rose(rst_n) |->
      vga_hsync && vga_vsync && sram_we_n && sram_oe_n && rgb == 0 && overrun_cnt == 0)
    else begin
      errors++;
      $display("Fail at %0t ns: outputs not idle after reset", $time);
    end

  a_hs_width : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      $rose(vga_hsync) |-> hs_low_len == h_sp)
    else begin
      errors++;
      $display("Fail at %0t ns: hsync low for %0d cycles, expected %0d", $time, hs_low_len, h_sp);
    end

  a_hs_period : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      h_lock && $fell(vga_hsync) |-> scr_h == h_vis + h_fp)
    else begin
      errors++;
      $display("Fail at %0t ns: hsync fell at column %0d", $time, scr_h);
    end

  a_vs_width : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      $rose(vga_vsync) |-> vs_low_len == v_sp * h_tot)
    else begin
      errors++;
      $display("Fail at %0t ns: vsync low for %0d cycles", $time, vs_low_len);
    end

  a_vs_period : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      v_lock && $fell(vga_vsync) |-> scr_v == v_vis + v_fp && scr_h == 0)
    else begin
      errors++;
      $display("Fail at %0t ns: vsync fell at line %0d column %0d", $time, scr_v, scr_h);
    end

  a_blank : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      locked && !on_screen |-> rgb == 0)
    else begin
      errors++;
      $display("Fail at %0t ns: rgb %h outside the visible area", $time, rgb);
    end

  a_pixel : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      pix_check |-> rgb == pix_exp)
    else begin
      errors++;
      $display("Fail at %0t ns: pixel %0d,%0d shows %h, expected %h",
               $time, scr_h, scr_v, rgb, pix_exp);
    end

  a_wr_addr : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      !sram_we_n |-> wr_known)
    else begin
      errors++;
      $display("Fail at %0t ns: write of %h to address %0d matches no sample",
               $time, sram_data, sram_addr);
    end

  a_bus_excl : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      sram_we_n || sram_oe_n)
    else begin
      errors++;
      $display("Fail at %0t ns: we_n and oe_n low together", $time);
    end

  a_no_wr_in_read : assert property (@(posedge pixel_clk) disable iff (!rst_n)
      rd_slot |-> sram_we_n)
    else begin
      errors++;
      $display("Fail at %0t ns: write in read slot %0d,%0d", $time, cnt_h, cnt_v);
    end

  initial begin
    int burst_len;
    int gap;
    int target;
    seed      = 32'hd1dc_b327;
    rst_n     = 1'b0;
    adc_x     = '0;
    adc_y     = '0;
    adc_red   = 1'b0;
    adc_grn   = 1'b0;
    adc_blu   = 1'b0;
    adc_valid = 1'b0;
    repeat (reset_cycles) @(negedge pixel_clk);
    rst_n = 1'b1;
    // bursts of back-to-back strobes provoke overruns
    for (int b = 0; b < bursts; b++) begin
      burst_len = 1 + $unsigned($random(seed)) % max_burst;
      for (int k = 0; k < burst_len; k++) begin
        drive_sample();
        @(negedge pixel_clk);
      end
      adc_valid = 1'b0;
      gap = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) @(negedge pixel_clk);
    end
    adc_valid = 1'b0;
    target = frames_seen + 2;
    wait (frames_seen >= target);
    a_overrun_total : assert (overrun_cnt == 16'(in_range_cnt - wr_count))
      else begin
        errors++;
        $display("Fail at %0t ns: overrun_cnt %0d, expected %0d",
                 $time, overrun_cnt, in_range_cnt - wr_count);
      end
    a_overrun_seen : assert (overrun_cnt != 0)
      else begin
        errors++;
        $display("no sample was dropped, so overrun counting went untested");
      end
    a_pix_seen : assert (pix_checks != 0)
      else begin
        errors++;
        $display("no plotted pixel was ever compared on screen");
      end
    $display("in-range samples %0d, writes %0d, overruns %0d, pixel checks %0d, errors %0d",
             in_range_cnt, wr_count, overrun_cnt, pix_checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns before the run completed", watchdog_ns);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/sram_model.sv
// asynchronous SRAM model: word array, tri-state read data and a one-entry write log
`timescale 1ns/1ns
`default_nettype none

module sram_model #(
  parameter int addr_width = 18,
  parameter int data_width = 16
) (
  input  wire                   log_clk,
  input  wire  [addr_width-1:0] addr,
  inout  wire  [data_width-1:0] data,
  input  wire                   we_n,
  input  wire                   oe_n,
  output logic                  wr_log_valid,
  output logic [addr_width-1:0] wr_log_addr,
  output logic [data_width-1:0] wr_log_data,
  output int                    wr_log_count
);

  logic [data_width-1:0] mem [2**addr_width];

  // power-up contents follow every address bit
  initial begin
    for (int i = 0; i < 2**addr_width; i++) begin
      mem[i] = data_width'(i ^ (i >> data_width) ^ (i >> 5));
    end
    wr_log_valid = 1'b0;
    wr_log_addr  = '0;
    wr_log_data  = '0;
    wr_log_count = 0;
  end

  // read data appears while output enable is low
  assign data = (!oe_n && we_n) ? mem[addr] : 'z;

  // a write is committed at the end of its bus cycle
  always @(posedge log_clk) begin
    wr_log_valid <= !we_n;
    if (!we_n) begin
      mem[addr]    <= data;
      wr_log_addr  <= addr;
      wr_log_data  <= data;
      wr_log_count <= wr_log_count + 1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/scope_top.sv
// x/y scope display top: adc sampling into an SRAM framebuffer shown on vga
`timescale 1ns/1ns
`default_nettype none

module scope_top
  import vga_pkg::*;
  import plot_pkg::*;
#(
  parameter int adc_data_width  = 10,
  parameter int sram_addr_width = 18,
  parameter int sram_data_width = 16,
  parameter int h_visible       = default_h_visible,
  parameter int h_front         = default_h_front,
  parameter int h_sync          = default_h_sync,
  parameter int h_back          = default_h_back,
  parameter int v_visible       = default_v_visible,
  parameter int v_front         = default_v_front,
  parameter int v_sync          = default_v_sync,
  parameter int v_back          = default_v_back,
  // framebuffer is half width, each stored pixel is shown twice
  parameter int fb_width        = h_visible / 2,
  parameter int fb_height       = v_visible
) (
  input  logic                       pixel_clk,
  input  logic                       rst_n,
  input  logic [adc_data_width-1:0]  adc_x,
  input  logic [adc_data_width-1:0]  adc_y,
  input  logic                       adc_red,
  input  logic                       adc_grn,
  input  logic                       adc_blu,
  input  logic                       adc_valid,
  output logic [sram_addr_width-1:0] sram_addr,
  inout  wire  [sram_data_width-1:0] sram_data,
  output logic                       sram_we_n,
  output logic                       sram_oe_n,
  output logic [color_width-1:0]     vga_red,
  output logic [color_width-1:0]     vga_grn,
  output logic [color_width-1:0]     vga_blu,
  output logic                       vga_hsync,
  output logic                       vga_vsync,
  output logic [15:0]                overrun_cnt
);

  logic [cnt_width-1:0]       hcount;
  logic [cnt_width-1:0]       vcount;
  logic                       visible;
  logic                       hsync_raw;
  logic                       vsync_raw;
  logic                       plot_valid;
  logic                       plot_ready;
  logic [sram_addr_width-1:0] plot_addr;
  pix_t                       plot_pix;
  logic                       rd_req;
  logic [sram_addr_width-1:0] rd_addr;
  pix_t                       rd_pix;
  logic                       overrun;

  vga_timing #(
    .h_visible(h_visible),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_visible(v_visible),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back)
  ) u_timing (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .hcount   (hcount),
    .vcount   (vcount),
    .visible  (visible),
    .hsync_raw(hsync_raw),
    .vsync_raw(vsync_raw)
  );

  adc_sampler #(
    .adc_data_width (adc_data_width),
    .sram_addr_width(sram_addr_width),
    .fb_width       (fb_width),
    .fb_height      (fb_height)
  ) u_sampler (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .adc_x     (adc_x),
    .adc_y     (adc_y),
    .adc_red   (adc_red),
    .adc_grn   (adc_grn),
    .adc_blu   (adc_blu),
    .adc_valid (adc_valid),
    .plot_ready(plot_ready),
    .plot_valid(plot_valid),
    .plot_addr (plot_addr),
    .plot_pix  (plot_pix),
    .overrun   (overrun)
  );

  sram_ctrl #(
    .sram_addr_width(sram_addr_width),
    .sram_data_width(sram_data_width)
  ) u_sram (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .hcount    (hcount),
    .visible   (visible),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .plot_valid(plot_valid),
    .plot_addr (plot_addr),
    .plot_pix  (plot_pix),
    .plot_ready(plot_ready),
    .rd_pix    (rd_pix),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n)
  );

  vga_pixel_out #(
    .sram_addr_width(sram_addr_width),
    .fb_width       (fb_width)
  ) u_pixel (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .hcount   (hcount),
    .vcount   (vcount),
    .visible  (visible),
    .hsync_raw(hsync_raw),
    .vsync_raw(vsync_raw),
    .rd_pix   (rd_pix),
    .rd_req   (rd_req),
    .rd_addr  (rd_addr),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

  // dropped samples, sticks at all ones
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      overrun_cnt <= '0;
    end else if (overrun && (overrun_cnt != 16'hffff)) begin
      overrun_cnt <= overrun_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vga_pixel_out.sv
// vga pixel output: framebuffer fetch, pixel doubling, blanking and sync alignment
`timescale 1ns/1ns
`default_nettype none

module vga_pixel_out
  import vga_pkg::*;
  import plot_pkg::*;
#(
  parameter int sram_addr_width = 18,
  parameter int fb_width        = 320
) (
  input  logic                       pixel_clk,
  input  logic                       rst_n,
  input  logic [cnt_width-1:0]       hcount,
  input  logic [cnt_width-1:0]       vcount,
  input  logic                       visible,
  input  logic                       hsync_raw,
  input  logic                       vsync_raw,
  input  pix_t                       rd_pix,
  output logic                       rd_req,
  output logic [sram_addr_width-1:0] rd_addr,
  output logic [color_width-1:0]     vga_red,
  output logic [color_width-1:0]     vga_grn,
  output logic [color_width-1:0]     vga_blu,
  output logic                       vga_hsync,
  output logic                       vga_vsync
);

  logic rd_req_d1;
  logic visible_d1;
  logic hsync_d1;
  logic vsync_d1;
  rgb_t pix_rgb;

  function automatic rgb_t expand(input pix_t pix);
    rgb_t c;
    c.red = {color_width{pix.red}};
    c.grn = {color_width{pix.grn}};
    c.blu = {color_width{pix.blu}};
    return c;
  endfunction

  // one fetch per stored pixel, which covers two screen columns
  assign rd_req  = visible && !hcount[0];
  assign rd_addr = sram_addr_width'(vcount) * sram_addr_width'(fb_width) +
                   sram_addr_width'(hcount[cnt_width-1:1]);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      rd_req_d1  <= 1'b0;
      visible_d1 <= 1'b0;
      hsync_d1   <= 1'b1;
      vsync_d1   <= 1'b1;
      pix_rgb    <= '0;
      vga_hsync  <= 1'b1;
      vga_vsync  <= 1'b1;
    end else begin
      rd_req_d1  <= rd_req;
      visible_d1 <= visible;
      hsync_d1   <= hsync_raw;
      vsync_d1   <= vsync_raw;
      vga_hsync  <= hsync_d1;
      vga_vsync  <= vsync_d1;
      // odd column keeps the colour fetched for the even one
      if (!visible_d1) begin
        pix_rgb <= '0;
      end else if (rd_req_d1) begin
        pix_rgb <= expand(rd_pix);
      end
    end
  end

  assign vga_red = pix_rgb.red;
  assign vga_grn = pix_rgb.grn;
  assign vga_blu = pix_rgb.blu;

endmodule

`default_nettype wire

// File: hdl/sram_ctrl.sv
// sram controller: splits cycles into display reads and plot writes, drives the SRAM pins
`timescale 1ns/1ns
`default_nettype none

module sram_ctrl
  import vga_pkg::*;
  import plot_pkg::*;
#(
  parameter int sram_addr_width = 18,
  parameter int sram_data_width = 16
) (
  input  logic                       pixel_clk,
  input  logic                       rst_n,
  input  logic [cnt_width-1:0]       hcount,
  input  logic                       visible,
  input  logic                       rd_req,
  input  logic [sram_addr_width-1:0] rd_addr,
  input  logic                       plot_valid,
  input  logic [sram_addr_width-1:0] plot_addr,
  input  pix_t                       plot_pix,
  output logic                       plot_ready,
  output pix_t                       rd_pix,
  output logic [sram_addr_width-1:0] sram_addr,
  inout  wire  [sram_data_width-1:0] sram_data,
  output logic                       sram_we_n,
  output logic                       sram_oe_n
);

  sram_op_e                   op;
  logic                       read_slot;
  logic [sram_data_width-1:0] wr_word;

  // display owns even visible pixels, everything else is free for plotting
  assign read_slot  = visible && !hcount[0];
  assign plot_ready = !read_slot;

  always_comb begin
    op = sram_idle;
    if (read_slot) begin
      if (rd_req) begin
        op = sram_read;
      end
    end else if (plot_valid) begin
      op = sram_write;
    end
  end

  always_comb begin
    wr_word      = '0;
    wr_word[2:0] = plot_pix;
  end

  assign sram_addr = (op == sram_write) ? plot_addr : rd_addr;
  assign sram_we_n = (op != sram_write);
  assign sram_oe_n = (op != sram_read);

  // bus is only driven for the single write cycle
  assign sram_data = (op == sram_write) ? wr_word : 'z;

  // pixel lives in the low three bits of the word
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      rd_pix <= '0;
    end else if (op == sram_read) begin
      rd_pix <= pix_t'(sram_data[2:0]);
    end
  end

  // pixel output stage must request only on its own slots
  a_rd_in_slot : assert property (@(posedge pixel_clk) disable iff (!rst_n)
    rd_req |-> read_slot);

endmodule

`default_nettype wire

// File: hdl/adc_sampler.sv
// adc sampler: range check, framebuffer address and a one-deep hold with overrun flag
`timescale 1ns/1ns
`default_nettype none

module adc_sampler
  import plot_pkg::*;
#(
  parameter int adc_data_width  = 10,
  parameter int sram_addr_width = 18,
  parameter int fb_width        = 320,
  parameter int fb_height       = 480
) (
  input  logic                       pixel_clk,
  input  logic                       rst_n,
  input  logic [adc_data_width-1:0]  adc_x,
  input  logic [adc_data_width-1:0]  adc_y,
  input  logic                       adc_red,
  input  logic                       adc_grn,
  input  logic                       adc_blu,
  input  logic                       adc_valid,
  input  logic                       plot_ready,
  output logic                       plot_valid,
  output logic [sram_addr_width-1:0] plot_addr,
  output pix_t                       plot_pix,
  output logic                       overrun
);

  sample_state_e state;
  logic          accept;
  logic          drain;
  logic          load;

  // samples off the framebuffer never enter the hold
  assign accept = adc_valid && (adc_x < fb_width) && (adc_y < fb_height);
  assign drain  = plot_valid && plot_ready;
  assign load   = accept && ((state == smp_empty) || drain);

  assign plot_valid = (state == smp_full);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state   <= smp_empty;
      overrun <= 1'b0;
    end else begin
      overrun <= accept && !load;
      if (load) begin
        state <= smp_full;
      end else if (drain) begin
        state <= smp_empty;
      end
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (load) begin
      plot_addr <= sram_addr_width'(adc_y) * sram_addr_width'(fb_width) +
                   sram_addr_width'(adc_x);
      plot_pix  <= '{red: adc_red, grn: adc_grn, blu: adc_blu};
    end
  end

  // a waiting sample must not move under the controller
  a_addr_stable : assert property (@(posedge pixel_clk) disable iff (!rst_n)
    plot_valid && !plot_ready |=> $stable(plot_addr));

endmodule

`default_nettype wire

// File: hdl/vga_timing.sv
// vga timing generator: pixel and line counters with registered syncs and visible flag
`timescale 1ns/1ns
`default_nettype none

module vga_timing
  import vga_pkg::*;
#(
  parameter int h_visible = default_h_visible,
  parameter int h_front   = default_h_front,
  parameter int h_sync    = default_h_sync,
  parameter int h_back    = default_h_back,
  parameter int v_visible = default_v_visible,
  parameter int v_front   = default_v_front,
  parameter int v_sync    = default_v_sync,
  parameter int v_back    = default_v_back
) (
  input  logic                 pixel_clk,
  input  logic                 rst_n,
  output logic [cnt_width-1:0] hcount,
  output logic [cnt_width-1:0] vcount,
  output logic                 visible,
  output logic                 hsync_raw,
  output logic                 vsync_raw
);

  localparam int h_total      = h_visible + h_front + h_sync + h_back;
  localparam int v_total      = v_visible + v_front + v_sync + v_back;
  localparam int h_sync_start = h_visible + h_front;
  localparam int v_sync_start = v_visible + v_front;

  logic [cnt_width-1:0] h_next;
  logic [cnt_width-1:0] v_next;

  always_comb begin
    h_next = hcount + 1'b1;
    v_next = vcount;
    if (hcount == cnt_width'(h_total - 1)) begin
      h_next = '0;
      v_next = (vcount == cnt_width'(v_total - 1)) ? '0 : vcount + 1'b1;
    end
  end

  // flags are computed from the next count so they line up with the counters
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      // park on the last pixel of the frame, first cycle out of reset is 0,0
      hcount    <= cnt_width'(h_total - 1);
      vcount    <= cnt_width'(v_total - 1);
      visible   <= 1'b0;
      hsync_raw <= 1'b1;
      vsync_raw <= 1'b1;
    end else begin
      hcount    <= h_next;
      vcount    <= v_next;
      visible   <= (h_next < cnt_width'(h_visible)) && (v_next < cnt_width'(v_visible));
      hsync_raw <= !((h_next >= cnt_width'(h_sync_start)) &&
                     (h_next < cnt_width'(h_sync_start + h_sync)));
      vsync_raw <= !((v_next >= cnt_width'(v_sync_start)) &&
                     (v_next < cnt_width'(v_sync_start + v_sync)));
    end
  end

  // sync pulse sits entirely in the blanking interval
  a_hsync_blank : assert property (@(posedge pixel_clk) disable iff (!rst_n)
    visible |-> hsync_raw);

endmodule

`default_nettype wire

// File: hdl/plot_pkg.sv
// plot path package: stored pixel format, SRAM cycle operations, sampler states
`default_nettype none

package plot_pkg;

  // one bit per channel, stored in the low bits of an SRAM word
  typedef struct packed {
    logic red;
    logic grn;
    logic blu;
  } pix_t;

  // what the SRAM controller does in a given cycle
  typedef enum logic [1:0] {
    sram_idle,
    sram_read,
    sram_write
  } sram_op_e;

  // hold register of the ADC sampler
  typedef enum logic {
    smp_empty,
    smp_full
  } sample_state_e;

endpackage

`default_nettype wire

// File: hdl/vga_pkg.sv
// vga display package: mode timing defaults, counter width and colour types
`default_nettype none

package vga_pkg;

  // 640x480 at 60 Hz, in pixel clocks
  localparam int default_h_visible = 640;
  localparam int default_h_front   = 16;
  localparam int default_h_sync    = 96;
  localparam int default_h_back    = 48;

  // same mode, in lines
  localparam int default_v_visible = 480;
  localparam int default_v_front   = 10;
  localparam int default_v_sync    = 2;
  localparam int default_v_back    = 33;

  // wide enough for the 800x525 frame with room to spare
  localparam int cnt_width = 11;

  localparam int color_width = 4;

  typedef struct packed {
    logic [color_width-1:0] red;
    logic [color_width-1:0] grn;
    logic [color_width-1:0] blu;
  } rgb_t;

endpackage

`default_nettype wire
